// File: compile.f
rtl/cpu_ctrl_pkg.sv
rtl/decode_if.sv
rtl/ir_decoder.sv
rtl/step_sequencer.sv
rtl/datapath_ctrl.sv
rtl/bus_ctrl.sv
rtl/cpu_control.sv
tests/cpu_control_properties.sv
tests/tb_cpu_control.sv

// File: rtl/bus_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module bus_ctrl (
  input  cpu_ctrl_pkg::phase_e phase,
  input  cpu_ctrl_pkg::seq_t   seq,
  decode_if.ctrl_view          dec,
  input  logic [1:0]           bus_align,
  output logic                 bus_read,
  output logic                 bus_write,
  output logic                 addrsel,
  output cpu_ctrl_pkg::lane_t  byteenable
);

  cpu_ctrl_pkg::lane_t lanes;
  logic                mem_op;

  always_comb begin
    case (dec.mem_size)
      cpu_ctrl_pkg::size_word: lanes = bus_align[1] ? 4'b0011 : 4'b1100;
      cpu_ctrl_pkg::size_byte: lanes = 4'b1000 >> bus_align;  // align 0 is msb lane
      default:                 lanes = cpu_ctrl_pkg::lanes_all;
    endcase
  end

  assign mem_op = phase == cpu_ctrl_pkg::phase_eval &&
                  (dec.op_class == cpu_ctrl_pkg::class_load ||
                   dec.op_class == cpu_ctrl_pkg::class_store);

  always_comb begin
    bus_read   = 1'b0;
    bus_write  = 1'b0;
    addrsel    = mem_op;  // mar drives the address bus
    byteenable = cpu_ctrl_pkg::lanes_all;
    if (phase == cpu_ctrl_pkg::phase_fetch) begin
      bus_read = (seq == 3'd0 || seq == 3'd1);
    end else if (mem_op && seq == 3'd2) begin
      bus_read   = (dec.op_class == cpu_ctrl_pkg::class_load);
      bus_write  = (dec.op_class == cpu_ctrl_pkg::class_store);
      byteenable = lanes;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
  input  logic                    clock,
  input  logic                    reset_n,
  input  cpu_ctrl_pkg::instr_t    ir,
  input  cpu_ctrl_pkg::ccr_t      ccr,
  input  logic                    bus_wait,
  input  logic [1:0]              bus_align,
  output logic                    ir_write,
  output logic                    ccr_write,
  output cpu_ctrl_pkg::alu_func_e alu_func,
  output cpu_ctrl_pkg::alu2sel_e  alu2sel,
  output cpu_ctrl_pkg::regsel_e   regsel,
  output cpu_ctrl_pkg::reg_addr_t reg_read_addr1,
  output cpu_ctrl_pkg::reg_addr_t reg_read_addr2,
  output cpu_ctrl_pkg::reg_addr_t reg_write_addr,
  output logic                    reg_write,
  output cpu_ctrl_pkg::mdrsel_e   mdrsel,
  output cpu_ctrl_pkg::marsel_e   marsel,
  output cpu_ctrl_pkg::pcsel_e    pcsel,
  output logic                    addrsel,
  output cpu_ctrl_pkg::lane_t     byteenable,
  output logic                    bus_read,
  output logic                    bus_write
);

  cpu_ctrl_pkg::phase_e phase;
  cpu_ctrl_pkg::seq_t   seq;

  decode_if dec ();  // decoded fields shared by all stages

  ir_decoder u_ir_decoder (
    .ir  (ir),
    .ccr (ccr),
    .dec (dec.source)
  );

  step_sequencer u_step_sequencer (
    .clock    (clock),
    .reset_n  (reset_n),
    .bus_wait (bus_wait),
    .dec      (dec.seq_view),
    .phase    (phase),
    .seq      (seq)
  );

  datapath_ctrl u_datapath_ctrl (
    .phase          (phase),
    .seq            (seq),
    .dec            (dec.ctrl_view),
    .ir_write       (ir_write),
    .ccr_write      (ccr_write),
    .alu_func       (alu_func),
    .alu2sel        (alu2sel),
    .regsel         (regsel),
    .reg_read_addr1 (reg_read_addr1),
    .reg_read_addr2 (reg_read_addr2),
    .reg_write_addr (reg_write_addr),
    .reg_write      (reg_write),
    .mdrsel         (mdrsel),
    .marsel         (marsel),
    .pcsel          (pcsel)
  );

  bus_ctrl u_bus_ctrl (
    .phase      (phase),
    .seq        (seq),
    .dec        (dec.ctrl_view),
    .bus_align  (bus_align),
    .bus_read   (bus_read),
    .bus_write  (bus_write),
    .addrsel    (addrsel),
    .byteenable (byteenable)
  );

endmodule

`default_nettype wire

// File: rtl/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [3:0]  ccr_t;   // carry, negative, overflow, zero
  typedef logic [3:0]  lane_t;  // msb lane first
  typedef logic [2:0]  seq_t;

  // instruction field positions
  localparam int unsigned mode_msb = 31;
  localparam int unsigned mode_lsb = 29;
  localparam int unsigned op_msb   = 28;
  localparam int unsigned op_lsb   = 21;
  localparam int unsigned ra_msb   = 20;
  localparam int unsigned ra_lsb   = 16;
  localparam int unsigned rb_msb   = 15;
  localparam int unsigned rb_lsb   = 11;
  localparam int unsigned rc_msb   = 10;
  localparam int unsigned rc_lsb   = 6;

  localparam lane_t lanes_all = 4'b1111;

  typedef enum logic [2:0] {
    mode_reg     = 3'h0,
    mode_reg_ind = 3'h1,
    mode_imm     = 3'h2,
    mode_dir     = 3'h4
  } addr_mode_e;

  typedef enum logic [1:0] {
    phase_fetch = 2'd0,
    phase_eval  = 2'd1,
    phase_fault = 2'd2
  } phase_e;

  typedef enum logic [2:0] {
    class_alu_rr,   // ra <= rb op rc
    class_alu_1,    // inc, dec
    class_move_1,   // mov, com, neg
    class_compare,
    class_branch,
    class_load,
    class_store,
    class_illegal
  } op_class_e;

  typedef enum logic [1:0] {size_long, size_word, size_byte} mem_size_e;

  typedef enum logic [2:0] {alu_add = 3'h2, alu_sub = 3'h3} alu_func_e;

  typedef enum logic [2:0] {
    pc_hold = 3'h0, pc_increment = 3'h1, pc_from_mar = 3'h2, pc_rel_branch = 3'h3
  } pcsel_e;

  typedef enum logic [3:0] {
    reg_alu_out = 4'h0, reg_mdr = 4'h1, reg_negate = 4'h2, reg_complement = 4'h3,
    reg_rb_data = 4'h4
  } regsel_e;

  typedef enum logic [2:0] {
    alu2_rb_data = 3'h0, alu2_displacement = 3'h1, alu2_const_one = 3'h2
  } alu2sel_e;

  typedef enum logic [2:0] {mdr_hold = 3'h0, mdr_bus_data = 3'h1, mdr_ra_data = 3'h3} mdrsel_e;

  typedef enum logic [1:0] {mar_hold = 2'h0, mar_alu_out = 2'h2} marsel_e;

endpackage

`default_nettype wire

// File: rtl/datapath_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module datapath_ctrl (
  input  cpu_ctrl_pkg::phase_e    phase,
  input  cpu_ctrl_pkg::seq_t      seq,
  decode_if.ctrl_view             dec,
  output logic                    ir_write,
  output logic                    ccr_write,
  output cpu_ctrl_pkg::alu_func_e alu_func,
  output cpu_ctrl_pkg::alu2sel_e  alu2sel,
  output cpu_ctrl_pkg::regsel_e   regsel,
  output cpu_ctrl_pkg::reg_addr_t reg_read_addr1,
  output cpu_ctrl_pkg::reg_addr_t reg_read_addr2,
  output cpu_ctrl_pkg::reg_addr_t reg_write_addr,
  output logic                    reg_write,
  output cpu_ctrl_pkg::mdrsel_e   mdrsel,
  output cpu_ctrl_pkg::marsel_e   marsel,
  output cpu_ctrl_pkg::pcsel_e    pcsel
);

  always_comb begin
    ir_write       = 1'b0;
    ccr_write      = 1'b0;
    alu_func       = cpu_ctrl_pkg::alu_add;
    alu2sel        = cpu_ctrl_pkg::alu2_rb_data;
    regsel         = cpu_ctrl_pkg::reg_alu_out;
    reg_read_addr1 = dec.ra;
    reg_read_addr2 = dec.rb;
    reg_write_addr = dec.ra;  // every write goes to ra
    reg_write      = 1'b0;
    mdrsel         = cpu_ctrl_pkg::mdr_hold;
    marsel         = cpu_ctrl_pkg::mar_hold;
    pcsel          = cpu_ctrl_pkg::pc_hold;

    if (phase == cpu_ctrl_pkg::phase_fetch) begin
      ir_write = (seq == 3'd1);  // latch bus into ir
      if (seq == 3'd2)
        pcsel = cpu_ctrl_pkg::pc_increment;
    end else if (phase == cpu_ctrl_pkg::phase_eval) begin
      case (dec.op_class)
        cpu_ctrl_pkg::class_alu_rr: begin
          alu_func       = dec.alu_func;
          reg_read_addr1 = dec.rb;
          reg_read_addr2 = dec.rc;
          reg_write      = (seq == 3'd1);
        end
        cpu_ctrl_pkg::class_alu_1: begin
          alu_func  = dec.alu_func;
          alu2sel   = cpu_ctrl_pkg::alu2_const_one;  // ra +/- 1
          reg_write = (seq == 3'd1);
        end
        cpu_ctrl_pkg::class_move_1: begin
          regsel    = dec.move_src;
          reg_write = 1'b1;
        end
        cpu_ctrl_pkg::class_compare: begin
          alu_func  = dec.alu_func;
          ccr_write = 1'b1;
        end
        cpu_ctrl_pkg::class_branch: begin
          if (dec.branch_taken)
            pcsel = cpu_ctrl_pkg::pc_rel_branch;
        end
        cpu_ctrl_pkg::class_load,
        cpu_ctrl_pkg::class_store: begin
          case (seq)
            3'd0: begin
              reg_read_addr1 = dec.rb;
              alu2sel        = cpu_ctrl_pkg::alu2_displacement;  // rb + disp
            end
            3'd1: marsel = cpu_ctrl_pkg::mar_alu_out;
            3'd2: begin
              if (dec.op_class == cpu_ctrl_pkg::class_load)
                mdrsel = cpu_ctrl_pkg::mdr_bus_data;
              else
                mdrsel = cpu_ctrl_pkg::mdr_ra_data;
            end
            3'd3: begin
              if (dec.op_class == cpu_ctrl_pkg::class_load) begin
                regsel    = cpu_ctrl_pkg::reg_mdr;
                reg_write = 1'b1;
              end
            end
            default: ;
          endcase
        end
        default: ;  // illegal, machine heads to fault
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_if.sv
`timescale 1ns/100ps
`default_nettype none

interface decode_if;
  cpu_ctrl_pkg::op_class_e op_class;
  cpu_ctrl_pkg::mem_size_e mem_size;
  cpu_ctrl_pkg::alu_func_e alu_func;
  cpu_ctrl_pkg::regsel_e   move_src;  // result select for mov/com/neg
  cpu_ctrl_pkg::reg_addr_t ra;
  cpu_ctrl_pkg::reg_addr_t rb;
  cpu_ctrl_pkg::reg_addr_t rc;
  logic                    branch_taken;

  modport source (
    output op_class, mem_size, alu_func, move_src, ra, rb, rc, branch_taken
  );

  modport seq_view (input op_class);

  modport ctrl_view (
    input op_class, mem_size, alu_func, move_src, ra, rb, rc, branch_taken
  );
endinterface

`default_nettype wire

// File: rtl/ir_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module ir_decoder (
  input  cpu_ctrl_pkg::instr_t ir,
  input  cpu_ctrl_pkg::ccr_t   ccr,
  decode_if.source             dec
);

  cpu_ctrl_pkg::addr_mode_e mode;
  cpu_ctrl_pkg::opcode_t    op;
  logic carry, negative, overflow, zero;

  assign mode = cpu_ctrl_pkg::addr_mode_e'(ir[cpu_ctrl_pkg::mode_msb:cpu_ctrl_pkg::mode_lsb]);
  assign op   = ir[cpu_ctrl_pkg::op_msb:cpu_ctrl_pkg::op_lsb];
  assign {carry, negative, overflow, zero} = ccr;

  assign dec.ra = ir[cpu_ctrl_pkg::ra_msb:cpu_ctrl_pkg::ra_lsb];
  assign dec.rb = ir[cpu_ctrl_pkg::rb_msb:cpu_ctrl_pkg::rb_lsb];
  assign dec.rc = ir[cpu_ctrl_pkg::rc_msb:cpu_ctrl_pkg::rc_lsb];

  always_comb begin
    dec.op_class = cpu_ctrl_pkg::class_illegal;
    dec.mem_size = cpu_ctrl_pkg::size_long;
    dec.alu_func = cpu_ctrl_pkg::alu_add;
    dec.move_src = cpu_ctrl_pkg::reg_rb_data;
    case (mode)
      cpu_ctrl_pkg::mode_reg: begin
        case (op) inside
          [8'h20:8'h27]: begin
            dec.op_class = cpu_ctrl_pkg::class_alu_rr;
            dec.alu_func = cpu_ctrl_pkg::alu_func_e'(op[2:0]);
          end
          8'h02: begin
            dec.op_class = cpu_ctrl_pkg::class_compare;
            dec.alu_func = cpu_ctrl_pkg::alu_sub;
          end
          8'h03: dec.op_class = cpu_ctrl_pkg::class_alu_1;  // inc
          8'h04: begin                                      // dec
            dec.op_class = cpu_ctrl_pkg::class_alu_1;
            dec.alu_func = cpu_ctrl_pkg::alu_sub;
          end
          8'h07: dec.op_class = cpu_ctrl_pkg::class_move_1;  // mov
          8'h08: begin                                       // com
            dec.op_class = cpu_ctrl_pkg::class_move_1;
            dec.move_src = cpu_ctrl_pkg::reg_complement;
          end
          8'h09: begin                                       // neg
            dec.op_class = cpu_ctrl_pkg::class_move_1;
            dec.move_src = cpu_ctrl_pkg::reg_negate;
          end
          default: ;
        endcase
      end
      cpu_ctrl_pkg::mode_imm: begin
        if (op <= 8'h0b)
          dec.op_class = cpu_ctrl_pkg::class_branch;
      end
      cpu_ctrl_pkg::mode_reg_ind: begin
        if (op <= 8'h05) begin
          dec.op_class = op[0] ? cpu_ctrl_pkg::class_load : cpu_ctrl_pkg::class_store;
          case (op[2:1])
            2'b01:   dec.mem_size = cpu_ctrl_pkg::size_word;
            2'b10:   dec.mem_size = cpu_ctrl_pkg::size_byte;
            default: dec.mem_size = cpu_ctrl_pkg::size_long;
          endcase
        end
      end
      cpu_ctrl_pkg::mode_dir: dec.op_class = cpu_ctrl_pkg::class_illegal;  // no direct operands
      default: dec.op_class = cpu_ctrl_pkg::class_illegal;
    endcase
  end

  always_comb begin
    case (op[3:0])
      4'h0:    dec.branch_taken = 1'b1;                               // bra
      4'h1:    dec.branch_taken = zero;                               // beq
      4'h2:    dec.branch_taken = ~zero;                              // bne
      4'h3:    dec.branch_taken = ~(zero | carry);                    // bgtu
      4'h4:    dec.branch_taken = ~(zero | (negative ^ overflow));    // bgt
      4'h5:    dec.branch_taken = ~(negative ^ overflow);             // bge
      4'h6:    dec.branch_taken = zero | (negative ^ overflow);       // ble
      4'h7:    dec.branch_taken = negative ^ overflow;                // blt
      4'h8:    dec.branch_taken = ~carry;                             // bgeu
      4'h9:    dec.branch_taken = carry;                              // bltu
      4'ha:    dec.branch_taken = carry | zero;                       // bleu
      4'hb:    dec.branch_taken = 1'b0;                               // brn
      default: dec.branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/step_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module step_sequencer (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 bus_wait,
  decode_if.seq_view           dec,
  output cpu_ctrl_pkg::phase_e phase,
  output cpu_ctrl_pkg::seq_t   seq
);

  cpu_ctrl_pkg::phase_e phase_next;
  cpu_ctrl_pkg::seq_t   seq_next;
  cpu_ctrl_pkg::seq_t   last_step;  // final eval step of this class
  logic                 bus_step;   // eval step that waits on the bus

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      phase <= cpu_ctrl_pkg::phase_fetch;
      seq   <= 3'd0;
    end else begin
      phase <= phase_next;
      seq   <= seq_next;
    end
  end

  always_comb begin
    case (dec.op_class)
      cpu_ctrl_pkg::class_alu_rr,
      cpu_ctrl_pkg::class_alu_1:  last_step = 3'd1;
      cpu_ctrl_pkg::class_load,
      cpu_ctrl_pkg::class_store:  last_step = 3'd3;
      default:                    last_step = 3'd0;  // single-cycle classes
    endcase
  end

  assign bus_step = (dec.op_class == cpu_ctrl_pkg::class_load ||
                     dec.op_class == cpu_ctrl_pkg::class_store) && seq == 3'd2;

  always_comb begin
    phase_next = phase;
    seq_next   = seq;
    case (phase)
      cpu_ctrl_pkg::phase_fetch: begin
        case (seq)
          3'd0: begin
            if (!bus_wait)  // wait for the bus
              seq_next = 3'd1;
          end
          3'd1: seq_next = 3'd2;  // ir latched here
          3'd2: begin
            seq_next   = 3'd0;
            phase_next = cpu_ctrl_pkg::phase_eval;
          end
          default: phase_next = cpu_ctrl_pkg::phase_fault;
        endcase
      end
      cpu_ctrl_pkg::phase_eval: begin
        if (dec.op_class == cpu_ctrl_pkg::class_illegal || seq > last_step) begin
          phase_next = cpu_ctrl_pkg::phase_fault;
        end else if (bus_step && bus_wait) begin
          seq_next = seq;  // stall on the bus
        end else if (seq == last_step) begin
          seq_next   = 3'd0;
          phase_next = cpu_ctrl_pkg::phase_fetch;
        end else begin
          seq_next = cpu_ctrl_pkg::seq_t'(seq + 3'd1);
        end
      end
      cpu_ctrl_pkg::phase_fault: phase_next = cpu_ctrl_pkg::phase_fault;  // only reset leaves
      default: phase_next = cpu_ctrl_pkg::phase_fault;
    endcase
  end

endmodule

`default_nettype wire

// File: tests/cpu_control_patterns.txt
# ir ccr align wait(-1 random) eval_len pcsel byteenable strobe(0 none 1 rd 2 wr 3 fault)
# reg_write_addr(ff none) alu_func regsel ccr_write
04432A40 0 0 2 2 0 f 0 03 2 0 0
04632A40 0 0 0 2 0 f 0 03 3 0 0
04A32A40 0 0 -1 2 0 f 0 03 5 0 0
00632A40 0 0 1 2 0 f 0 03 2 0 0
00832A40 0 0 0 2 0 f 0 03 3 0 0
00E32A40 0 0 0 1 0 f 0 03 2 4 0
01032A40 0 0 0 1 0 f 0 03 2 3 0
01232A40 0 0 0 1 0 f 0 03 2 2 0
00432A40 0 0 0 1 0 f 0 ff 3 0 1
40032A40 0 0 0 1 3 f 0 ff 2 0 0
41632A40 f 0 0 1 0 f 0 ff 2 0 0
40232A40 1 0 0 1 3 f 0 ff 2 0 0
40432A40 1 0 0 1 0 f 0 ff 2 0 0
40632A40 0 0 0 1 3 f 0 ff 2 0 0
40832A40 4 0 0 1 0 f 0 ff 2 0 0
40A32A40 6 0 0 1 3 f 0 ff 2 0 0
40C32A40 2 0 0 1 3 f 0 ff 2 0 0
40E32A40 0 0 0 1 0 f 0 ff 2 0 0
41032A40 8 0 0 1 0 f 0 ff 2 0 0
41232A40 8 0 0 1 3 f 0 ff 2 0 0
41432A40 0 0 0 1 0 f 0 ff 2 0 0
20232A40 0 1 2 4 0 f 1 03 2 1 0
20632A40 0 2 1 4 0 3 1 03 2 1 0
20A32A40 0 1 -1 4 0 4 1 03 2 1 0
20032A40 0 0 1 4 0 f 2 ff 2 0 0
20432A40 0 0 0 4 0 c 2 ff 2 0 0
20832A40 0 3 2 4 0 1 2 ff 2 0 0
80032A40 0 0 0 1 0 f 3 ff 2 0 0

// File: tests/cpu_control_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control_properties (
  input logic clock,
  input logic reset_n,
  input logic bus_wait,
  input logic bus_read,
  input logic bus_write,
  input logic ir_write
);

  logic        quiet;         // no bus or ir activity this cycle
  int unsigned failures = 0;  // failed assertion count

  assign quiet = !bus_read && !bus_write && !ir_write;

  a_strobe_excl: assert property (@(posedge clock) disable iff (!reset_n)
    !(bus_read && bus_write)) else begin
    failures++;
    $error("bus_read and bus_write high together");
  end

  a_ir_write_read: assert property (@(posedge clock) disable iff (!reset_n)
    ir_write |-> bus_read) else begin
    failures++;
    $error("ir_write without bus_read");
  end

  a_read_hold: assert property (@(posedge clock) disable iff (!reset_n)
    bus_read && bus_wait |=> bus_read) else begin
    failures++;
    $error("bus_read dropped during wait");
  end

  a_write_hold: assert property (@(posedge clock) disable iff (!reset_n)
    bus_write && bus_wait |=> bus_write) else begin
    failures++;
    $error("bus_write dropped during wait");
  end

  // only the fault state stays quiet this long
  a_fault_sticky: assert property (@(posedge clock) disable iff (!reset_n)
    quiet [*4] |=> quiet) else begin
    failures++;
    $error("activity after fault state");
  end

endmodule

`default_nettype wire

// File: tests/tb_cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_control;

  logic        clock;
  logic        reset_n;
  logic [31:0] ir;
  logic [3:0]  ccr;
  logic        bus_wait;
  logic [1:0]  bus_align;
  logic        ir_write;
  logic        ccr_write;
  logic        reg_write;
  logic        addrsel;
  logic        bus_read;
  logic        bus_write;
  logic [2:0]  alu_func;
  logic [2:0]  alu2sel;
  logic [3:0]  regsel;
  logic [4:0]  reg_read_addr1;
  logic [4:0]  reg_read_addr2;
  logic [4:0]  reg_write_addr;
  logic [2:0]  mdrsel;
  logic [1:0]  marsel;
  logic [2:0]  pcsel;
  logic [3:0]  byteenable;

  logic [31:0] p_ir [64];
  int          p_ccr [64];
  int          p_align [64];
  int          p_wait [64];
  int          p_len [64];
  int          p_pcsel [64];
  int          p_be [64];
  int          p_strobe [64];
  int          p_wr [64];
  int          p_alu [64];
  int          p_regsel [64];
  int          p_ccrw [64];
  int          n_pat;
  int          errors;
  int          failed_tests;
  int          cycles;
  int          limit = 100000;
  int unsigned seed = 32'h4134;

  cpu_control dut (.*);

  bind cpu_control cpu_control_properties props (
    .clock(clock), .reset_n(reset_n), .bus_wait(bus_wait),
    .bus_read(bus_read), .bus_write(bus_write), .ir_write(ir_write)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: DUT did not finish the patterns within %0d cycles", limit);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic int unsigned lcg_next(int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic mismatch(string name, int expected, int actual);
    $display("Fail at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic load_patterns();
    int    fd;
    int    sum_wait;
    string line;
    fd = $fopen("tests/cpu_control_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file");
      errors++;
      return;
    end
    n_pat = 0;
    sum_wait = 0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 8 || line[0] == "#")
        continue;
      void'($sscanf(line, "%h %h %h %d %d %h %h %d %h %h %h %h", p_ir[n_pat],
        p_ccr[n_pat], p_align[n_pat], p_wait[n_pat], p_len[n_pat], p_pcsel[n_pat],
        p_be[n_pat], p_strobe[n_pat], p_wr[n_pat], p_alu[n_pat], p_regsel[n_pat],
        p_ccrw[n_pat]));
      if (p_wait[n_pat] < 0) begin  // random wait count
        seed = lcg_next(seed);
        p_wait[n_pat] = (seed >> 16) % 4;
      end
      sum_wait += p_wait[n_pat];
      n_pat++;
    end
    $fclose(fd);
    limit = 40 * n_pat + sum_wait + 16;
  endtask

  // starts at the negedge of the first fetch cycle, ends at the next one
  task automatic run_test(int i);
    int w;
    int n;
    int strobes;
    int writes;
    int errors_before;
    int next_wait;
    int exp_alu2;
    int exp_mdr;
    int exp_mar;
    logic [2:0] last_pcsel;
    logic [2:0] last_alu;
    logic [3:0] last_regsel;
    logic       last_ccrw;
    logic       last_rw;
    logic [4:0] last_wr_addr;
    logic       mem;
    logic       rr;
    logic       incdec;
    w = p_wait[i];
    errors_before = errors;
    mem = (p_strobe[i] == 1 || p_strobe[i] == 2);
    rr = p_ir[i][31:29] == 3'd0 && p_ir[i][28:24] == 5'h04;
    incdec = !rr && !mem && p_len[i] == 2;  // the other two-step ops
    next_wait = (i + 1 < n_pat) ? p_wait[i + 1] : 0;
    for (int k = 0; k <= w; k++) begin
      if (!bus_read) mismatch("bus_read", 1, bus_read);
      if (ir_write) mismatch("ir_write", 0, ir_write);
      @(posedge clock);
      #2;
      bus_wait = (k + 1 < w);
      if (k == w) begin  // instruction word arrives in fetch step 1
        ir = p_ir[i];
        ccr = p_ccr[i];
        bus_align = p_align[i];
      end
      @(negedge clock);
    end
    if (!ir_write) mismatch("ir_write", 1, ir_write);
    if (!bus_read) mismatch("bus_read", 1, bus_read);
    @(posedge clock);
    @(negedge clock);
    if (pcsel !== 3'd1) mismatch("pcsel", 1, pcsel);
    if (ir_write || bus_read) mismatch("ir_write|bus_read", 0, ir_write | bus_read);
    if (p_strobe[i] == 3) begin
      for (int k = 0; k < 10; k++) begin
        @(negedge clock);
        if (bus_read || bus_write || ir_write || reg_write) begin
          $display("Fail at %0t: strobe or write active in fault state", $time);
          errors++;
        end
      end
    end else begin
      n = 0;
      strobes = 0;
      writes = 0;
      while (n <= p_len[i] + w + 4) begin
        @(posedge clock);
        #2;
        if (n == p_len[i] + (mem ? w : 0))
          bus_wait = (next_wait > 0);
        else
          bus_wait = mem && n >= 2 && n < 2 + w;
        @(negedge clock);
        if (bus_read && !addrsel)
          break;  // next fetch has begun
        if (n == 0 && rr) begin
          if (reg_read_addr1 !== p_ir[i][15:11])
            mismatch("reg_read_addr1", p_ir[i][15:11], reg_read_addr1);
          if (reg_read_addr2 !== p_ir[i][10:6])
            mismatch("reg_read_addr2", p_ir[i][10:6], reg_read_addr2);
        end
        if (n == 0 && mem && reg_read_addr1 !== p_ir[i][15:11])
          mismatch("reg_read_addr1", p_ir[i][15:11], reg_read_addr1);
        exp_mar = (mem && n == 1) ? 2 : 0;
        exp_mdr = (mem && n >= 2 && n <= 2 + w) ? ((p_strobe[i] == 1) ? 1 : 3) : 0;
        if (mem && n == 0)
          exp_alu2 = 1;  // base plus displacement
        else
          exp_alu2 = incdec ? 2 : 0;
        if (addrsel !== mem) mismatch("addrsel", mem, addrsel);
        if (marsel !== exp_mar) mismatch("marsel", exp_mar, marsel);
        if (mdrsel !== exp_mdr) mismatch("mdrsel", exp_mdr, mdrsel);
        if (alu2sel !== exp_alu2) mismatch("alu2sel", exp_alu2, alu2sel);
        if (bus_read || bus_write) begin
          strobes++;
          if (bus_write !== (p_strobe[i] == 2)) mismatch("bus_write", p_strobe[i] == 2, bus_write);
          if (byteenable !== p_be[i]) mismatch("byteenable", p_be[i], byteenable);
        end
        writes += reg_write;
        last_pcsel = pcsel;
        last_alu = alu_func;
        last_regsel = regsel;
        last_ccrw = ccr_write;
        last_rw = reg_write;
        last_wr_addr = reg_write_addr;
        n++;
      end
      if (n != p_len[i] + (mem ? w : 0)) mismatch("eval length", p_len[i] + (mem ? w : 0), n);
      if (last_pcsel !== p_pcsel[i]) mismatch("pcsel", p_pcsel[i], last_pcsel);
      if (last_alu !== p_alu[i]) mismatch("alu_func", p_alu[i], last_alu);
      if (last_regsel !== p_regsel[i]) mismatch("regsel", p_regsel[i], last_regsel);
      if (last_ccrw !== p_ccrw[i]) mismatch("ccr_write", p_ccrw[i], last_ccrw);
      if (strobes != (mem ? w + 1 : 0)) mismatch("strobe cycles", mem ? w + 1 : 0, strobes);
      if (p_wr[i] == 8'hff) begin
        if (writes != 0) mismatch("reg_write count", 0, writes);
      end else begin
        if (writes != 1 || !last_rw) mismatch("reg_write in last cycle", 1, writes);
        if (last_wr_addr !== p_wr[i]) mismatch("reg_write_addr", p_wr[i], last_wr_addr);
      end
    end
    if (errors != errors_before)
      failed_tests++;
    $display("test %0d ir %h wait %0d: %s", i, p_ir[i], w,
             (errors == errors_before) ? "ok" : "FAILED");
  endtask

  initial begin
    reset_n = 1'b0;
    ir = 32'h0;
    ccr = 4'h0;
    bus_wait = 1'b0;
    bus_align = 2'd0;
    errors = 0;
    failed_tests = 0;
    cycles = 0;
    load_patterns();
    repeat (15) @(posedge clock);
    @(negedge clock);
    if (!bus_read) mismatch("bus_read", 1, bus_read);
    if (ir_write || reg_write || ccr_write || bus_write) begin
      $display("Fail at %0t: write or bus_write active during reset", $time);
      errors++;
    end
    if (pcsel !== 3'd0) mismatch("pcsel", 0, pcsel);
    if (byteenable !== 4'hf) mismatch("byteenable", 4'hf, byteenable);
    @(posedge clock);
    #2;
    reset_n = 1'b1;
    bus_wait = (n_pat > 0 && p_wait[0] > 0);
    @(negedge clock);
    for (int i = 0; i < n_pat; i++)
      run_test(i);
    errors += dut.props.failures;
    $display("tests %0d, failed %0d, errors %0d", n_pat, failed_tests, errors);
    if (errors == 0 && n_pat > 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
